//--- periph_bus_pkg.sv
package periph_bus_pkg;

  //******************************
  // bus widths and port count
  //******************************

  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;

  localparam int NB_PERIPH = 4;

  // the low address bits that index inside one peripheral window
  localparam int PERIPH_OFFS_WIDTH = 12;

  // node port indices
  localparam int GPIO_IDX     = 0;
  localparam int SOC_CTRL_IDX = 1;
  localparam int TIMER_IDX    = 2;
  localparam int UDMA_IDX     = 3;

  //******************************
  // APB request and response
  //******************************

  // driven by the requester side of a link
  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  // driven by the completer side of a link
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_resp_t;

  //******************************
  // address map
  //******************************

  localparam logic [APB_ADDR_WIDTH-1:0] GPIO_START_ADDR     = 32'h1A10_1000;
  localparam logic [APB_ADDR_WIDTH-1:0] GPIO_END_ADDR       = 32'h1A10_1FFF;
  localparam logic [APB_ADDR_WIDTH-1:0] UDMA_START_ADDR     = 32'h1A10_2000;
  localparam logic [APB_ADDR_WIDTH-1:0] UDMA_END_ADDR       = 32'h1A10_3FFF;
  localparam logic [APB_ADDR_WIDTH-1:0] SOC_CTRL_START_ADDR = 32'h1A10_4000;
  localparam logic [APB_ADDR_WIDTH-1:0] SOC_CTRL_END_ADDR   = 32'h1A10_4FFF;
  localparam logic [APB_ADDR_WIDTH-1:0] TIMER_START_ADDR    = 32'h1A10_B000;
  localparam logic [APB_ADDR_WIDTH-1:0] TIMER_END_ADDR      = 32'h1A10_BFFF;

  // the highest port index comes first in the concatenation
  localparam logic [NB_PERIPH-1:0][APB_ADDR_WIDTH-1:0] PERIPH_START_ADDR = {
    UDMA_START_ADDR, TIMER_START_ADDR, SOC_CTRL_START_ADDR, GPIO_START_ADDR
  };
  localparam logic [NB_PERIPH-1:0][APB_ADDR_WIDTH-1:0] PERIPH_END_ADDR = {
    UDMA_END_ADDR, TIMER_END_ADDR, SOC_CTRL_END_ADDR, GPIO_END_ADDR
  };

  // timer register offsets inside its window
  localparam logic [PERIPH_OFFS_WIDTH-1:0] TIMER_COUNT_OFFS = 12'h000;
  localparam logic [PERIPH_OFFS_WIDTH-1:0] TIMER_CMP_OFFS   = 12'h004;
  localparam logic [PERIPH_OFFS_WIDTH-1:0] TIMER_CTRL_OFFS  = 12'h008;

endpackage

//--- periph_apb_node.sv
module periph_apb_node
  import periph_bus_pkg::*;
#(
  parameter int RTO_CYCLES = 16
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  apb_req_t                       apb_req_i,
  output apb_resp_t                      apb_resp_o,
  output apb_req_t  [NB_PERIPH-1:0]      port_req_o,
  input  apb_resp_t [NB_PERIPH-1:0]      port_resp_i,
  output logic      [NB_PERIPH-1:0]      peripheral_rto_o
);

  localparam int CNT_WIDTH = $clog2(RTO_CYCLES + 1);

  logic                 setup_phase;
  logic                 access_phase;
  logic [NB_PERIPH-1:0] hit;
  logic                 any_hit;
  logic                 miss;
  apb_resp_t            sel_resp;
  logic [CNT_WIDTH-1:0] rto_cnt_q;
  logic                 rto_fire;

  assign setup_phase  = apb_req_i.psel & ~apb_req_i.penable;
  assign access_phase = apb_req_i.psel & apb_req_i.penable;

  //******************************
  // address decode
  //******************************

  // windows do not overlap, so at most one bit of hit is set
  always_comb begin
    for (int i = 0; i < NB_PERIPH; i++) begin
      hit[i] = (apb_req_i.paddr >= PERIPH_START_ADDR[i]) &&
               (apb_req_i.paddr <= PERIPH_END_ADDR[i]);
    end
  end

  assign any_hit = |hit;
  assign miss    = apb_req_i.psel & ~any_hit;

  //******************************
  // response timeout
  //******************************

  // the counter holds the access cycles already spent without ready, so the
  // timeout decision never depends on the port's response in the same cycle
  assign rto_fire = access_phase & any_hit & (rto_cnt_q == CNT_WIDTH'(RTO_CYCLES));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rto_cnt_q <= '0;
    end else if (setup_phase || rto_fire) begin
      rto_cnt_q <= '0;
    end else if (access_phase && any_hit && !sel_resp.pready) begin
      rto_cnt_q <= rto_cnt_q + 1'b1;
    end
  end

  // one cycle pulse on the bit of the port that stalled
  assign peripheral_rto_o = hit & {NB_PERIPH{rto_fire}};

  //******************************
  // request fan-out
  //******************************

  // every port sees the address, data and phase but only psel is steered
  always_comb begin
    for (int i = 0; i < NB_PERIPH; i++) begin
      port_req_o[i]      = apb_req_i;
      port_req_o[i].psel = apb_req_i.psel & hit[i] & ~rto_fire;
    end
  end

  //******************************
  // response multiplexing
  //******************************

  always_comb begin
    sel_resp = '0;
    for (int i = 0; i < NB_PERIPH; i++) begin
      if (hit[i]) begin
        sel_resp = port_resp_i[i];
      end
    end
  end

  always_comb begin
    apb_resp_o = '0;
    if (miss) begin
      // nothing decodes here, so end the transfer with an error right away
      apb_resp_o.pready  = apb_req_i.penable;
      apb_resp_o.pslverr = apb_req_i.penable;
    end else if (rto_fire) begin
      apb_resp_o.pready  = 1'b1;
      apb_resp_o.pslverr = 1'b1;
    end else if (apb_req_i.psel) begin
      apb_resp_o = sel_resp;
    end
  end

endmodule

//--- periph_reg_bank.sv
module periph_reg_bank
  import periph_bus_pkg::*;
#(
  parameter int NB_REGS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  apb_req_t                              req_i,
  output apb_resp_t                             resp_o,
  output logic [NB_REGS-1:0][APB_DATA_WIDTH-1:0] regs_o
);

  localparam int IDX_WIDTH = PERIPH_OFFS_WIDTH - 2;

  logic [NB_REGS-1:0][APB_DATA_WIDTH-1:0] regs_q;
  logic [IDX_WIDTH-1:0]                   reg_idx;
  logic                                   idx_valid;
  logic                                   access;

  // the word index inside the window skips the two byte bits
  assign reg_idx   = req_i.paddr[PERIPH_OFFS_WIDTH-1:2];
  assign idx_valid = (int'(reg_idx) < NB_REGS);
  assign access    = req_i.psel & req_i.penable;

  //******************************
  // register write
  //******************************

  // the write lands on the edge that closes the access cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (access && req_i.pwrite && idx_valid) begin
      regs_q[reg_idx] <= req_i.pwdata;
    end
  end

  //******************************
  // register read and response
  //******************************

  // with no wait states ready comes with the first access cycle
  always_comb begin
    resp_o         = '0;
    resp_o.pready  = access;
    resp_o.pslverr = access & ~idx_valid;
    if (idx_valid) begin
      resp_o.prdata = regs_q[reg_idx];
    end
  end

  // the stored values leave the block as plain outputs
  assign regs_o = regs_q;

endmodule

//--- periph_timer.sv
module periph_timer
  import periph_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  apb_req_t  req_i,
  output apb_resp_t resp_o,
  output logic      event_o
);

  logic [APB_DATA_WIDTH-1:0]    count_q;
  logic [APB_DATA_WIDTH-1:0]    cmp_q;
  logic [APB_DATA_WIDTH-1:0]    ctrl_q;
  logic [PERIPH_OFFS_WIDTH-1:0] offs;
  logic                         access;
  logic                         wr_en;
  logic                         timer_en;
  logic                         match;

  assign offs     = req_i.paddr[PERIPH_OFFS_WIDTH-1:0];
  assign access   = req_i.psel & req_i.penable;
  assign wr_en    = access & req_i.pwrite;
  assign timer_en = ctrl_q[0];

  // a match only counts while the timer runs
  assign match   = timer_en & (count_q == cmp_q);
  assign event_o = match;

  //******************************
  // counter
  //******************************

  // a bus write to the count register wins over counting
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (wr_en && (offs == TIMER_COUNT_OFFS)) begin
      count_q <= req_i.pwdata;
    end else if (match) begin
      count_q <= '0;
    end else if (timer_en) begin
      count_q <= count_q + 1'b1;
    end
  end

  //******************************
  // compare and control
  //******************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmp_q  <= '0;
      ctrl_q <= '0;
    end else if (wr_en) begin
      if (offs == TIMER_CMP_OFFS) begin
        cmp_q <= req_i.pwdata;
      end
      if (offs == TIMER_CTRL_OFFS) begin
        ctrl_q <= req_i.pwdata;
      end
    end
  end

  // any offset other than the three registers answers with an error
  always_comb begin
    resp_o        = '0;
    resp_o.pready = access;
    case (offs)
      TIMER_COUNT_OFFS: resp_o.prdata = count_q;
      TIMER_CMP_OFFS:   resp_o.prdata = cmp_q;
      TIMER_CTRL_OFFS:  resp_o.prdata = ctrl_q;
      default: begin
        resp_o.pslverr = access;
      end
    endcase
  end

endmodule

//--- periph_bus_top.sv
module periph_bus_top
  import periph_bus_pkg::*;
#(
  parameter int RTO_CYCLES       = 16,
  parameter int GPIO_NB_REGS     = 2,
  parameter int SOC_CTRL_NB_REGS = 4
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  apb_req_t                                       apb_req_i,
  output apb_resp_t                                      apb_resp_o,
  output apb_req_t                                       udma_req_o,
  input  apb_resp_t                                      udma_resp_i,
  output logic      [GPIO_NB_REGS-1:0][APB_DATA_WIDTH-1:0] gpio_o,
  output logic [SOC_CTRL_NB_REGS-1:0][APB_DATA_WIDTH-1:0] soc_ctrl_o,
  output logic                                           timer_event_o,
  output logic      [NB_PERIPH-1:0]                      peripheral_rto_o
);

  apb_req_t  [NB_PERIPH-1:0] port_req;
  apb_resp_t [NB_PERIPH-1:0] port_resp;

  //******************************
  // input side
  //******************************

  periph_apb_node #(
    .RTO_CYCLES(RTO_CYCLES)
  ) node_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .apb_req_i       (apb_req_i),
    .apb_resp_o      (apb_resp_o),
    .port_req_o      (port_req),
    .port_resp_i     (port_resp),
    .peripheral_rto_o(peripheral_rto_o)
  );

  //******************************
  // peripherals
  //******************************

  periph_reg_bank #(
    .NB_REGS(GPIO_NB_REGS)
  ) gpio_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (port_req[GPIO_IDX]),
    .resp_o (port_resp[GPIO_IDX]),
    .regs_o (gpio_o)
  );

  periph_reg_bank #(
    .NB_REGS(SOC_CTRL_NB_REGS)
  ) soc_ctrl_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (port_req[SOC_CTRL_IDX]),
    .resp_o (port_resp[SOC_CTRL_IDX]),
    .regs_o (soc_ctrl_o)
  );

  periph_timer timer_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (port_req[TIMER_IDX]),
    .resp_o (port_resp[TIMER_IDX]),
    .event_o(timer_event_o)
  );

  //******************************
  // output side
  //******************************

  // the uDMA window is served outside this block
  assign udma_req_o          = port_req[UDMA_IDX];
  assign port_resp[UDMA_IDX] = udma_resp_i;

endmodule

//--- tb_periph_bus.sv
module tb_periph_bus
  import periph_bus_pkg::*;
();

  localparam int STALL      = -1;
  localparam int XFER_LIMIT = 40;
  localparam int TIMER_CMP  = 5;
  localparam int EVT_LIMIT  = 4 * (TIMER_CMP + 1) + 16;

  logic clk;
  logic reset;
  apb_req_t apb_req;
  apb_resp_t apb_resp;
  apb_req_t udma_req;
  apb_resp_t udma_resp = '0;
  logic [1:0][31:0] gpio;
  logic [3:0][31:0] soc_ctrl;
  logic timer_event;
  logic [NB_PERIPH-1:0] rto;

  integer seed = 85;
  int errors = 0;
  int checks = 0;
  int timeouts = 0;

  // the stimulus table holds one entry per transfer
  string t_name[$];
  logic [31:0] t_addr[$];
  bit t_write[$];
  logic [31:0] t_wdata[$];
  logic [31:0] t_rdata[$];
  bit t_err[$];
  int t_wait[$];
  bit t_rto[$];
  bit t_nosel[$];

  logic [31:0] wr_data[7];
  logic [31:0] rd_data;
  bit rd_err;
  bit timed_out;
  int cur_wait = 0;
  int rto_udma_cnt = 0;
  int rto_any_cnt = 0;
  int psel_cnt = 0;
  int rto_udma_before;
  int rto_any_before;
  int psel_before;
  int interval;

  periph_bus_top #(
    .RTO_CYCLES      (16),
    .GPIO_NB_REGS    (2),
    .SOC_CTRL_NB_REGS(4)
  ) UUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .apb_req_i       (apb_req),
    .apb_resp_o      (apb_resp),
    .udma_req_o      (udma_req),
    .udma_resp_i     (udma_resp),
    .gpio_o          (gpio),
    .soc_ctrl_o      (soc_ctrl),
    .timer_event_o   (timer_event),
    .peripheral_rto_o(rto)
  );

  always #4 clk = ~clk;

  //******************************
  // uDMA peripheral model
  //******************************

  logic [31:0] udma_mem[256];
  logic        udma_busy;
  int          udma_cnt;
  logic [7:0]  udma_idx;

  // bus state is tracked on the rising edge
  always @(posedge clk) begin
    if (reset) begin
      udma_busy <= 1'b0;
      udma_cnt  <= 0;
      udma_idx  <= '0;
      for (int a = 0; a < 256; a++) begin
        udma_mem[a] <= UDMA_START_ADDR + 32'(a * 4);
      end
    end else if (udma_req.psel && !udma_req.penable) begin
      udma_busy <= 1'b1;
      udma_cnt  <= 0;
      udma_idx  <= udma_req.paddr[9:2];
    end else if (udma_req.psel && udma_req.penable) begin
      if (udma_resp.pready) begin
        udma_busy <= 1'b0;
        if (udma_req.pwrite) begin
          udma_mem[udma_idx] <= udma_req.pwdata;
        end
      end else begin
        udma_cnt <= udma_cnt + 1;
      end
    end else begin
      udma_busy <= 1'b0;
    end
  end

  // the response for the next cycle goes out on the falling edge
  always @(negedge clk) begin
    udma_resp.pslverr = 1'b0;
    udma_resp.pready  = udma_busy && (cur_wait != STALL) && (udma_cnt >= cur_wait);
    udma_resp.prdata  = udma_resp.pready ? udma_mem[udma_idx] : '0;
  end

  // running counts of timeout pulses and port selects
  always @(posedge clk) begin
    if (rto[UDMA_IDX]) begin
      rto_udma_cnt <= rto_udma_cnt + 1;
    end
    if (|rto) begin
      rto_any_cnt <= rto_any_cnt + 1;
    end
    if (UUT.node_i.port_req_o[GPIO_IDX].psel || UUT.node_i.port_req_o[SOC_CTRL_IDX].psel ||
        UUT.node_i.port_req_o[TIMER_IDX].psel || udma_req.psel) begin
      psel_cnt <= psel_cnt + 1;
    end
  end

  //******************************
  // helpers
  //******************************

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] addr, input bit write,
                         input logic [31:0] wdata, input logic [31:0] rdata, input bit err,
                         input int wait_cycles, input bit exp_rto, input bit no_sel);
    t_name.push_back(name);
    t_addr.push_back(addr);
    t_write.push_back(write);
    t_wdata.push_back(wdata);
    t_rdata.push_back(rdata);
    t_err.push_back(err);
    t_wait.push_back(wait_cycles);
    t_rto.push_back(exp_rto);
    t_nosel.push_back(no_sel);
  endtask

  // drives one APB transfer through setup and access until pready or the limit
  task automatic apb_transfer(input logic [31:0] addr, input bit write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output bit err, output bit to);
    int cycles;
    cycles = 0;
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_resp.pready && cycles < XFER_LIMIT) begin
      cycles++;
      @(posedge clk);
    end
    to    = !apb_resp.pready;
    rdata = apb_resp.prdata;
    err   = apb_resp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  // returns the falling edges counted until the next timer event
  task automatic wait_timer_event(output int cycles, output bit to);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!timer_event && cycles < EVT_LIMIT);
    to = !timer_event;
  endtask

  task automatic build_table();
    for (int k = 0; k < 7; k++) begin
      wr_data[k] = $random(seed);
    end
    add_row("gpio_wr0", 32'h1A10_1000, 1, wr_data[0], '0, 0, 0, 0, 0);
    add_row("gpio_wr1", 32'h1A10_1004, 1, wr_data[1], '0, 0, 0, 0, 0);
    add_row("gpio_rd0", 32'h1A10_1000, 0, '0, wr_data[0], 0, 0, 0, 0);
    add_row("gpio_rd1", 32'h1A10_1004, 0, '0, wr_data[1], 0, 0, 0, 0);
    add_row("soc_wr0", 32'h1A10_4000, 1, wr_data[2], '0, 0, 0, 0, 0);
    add_row("soc_wr3", 32'h1A10_400C, 1, wr_data[3], '0, 0, 0, 0, 0);
    add_row("soc_rd0", 32'h1A10_4000, 0, '0, wr_data[2], 0, 0, 0, 0);
    add_row("soc_rd3", 32'h1A10_400C, 0, '0, wr_data[3], 0, 0, 0, 0);
    add_row("udma_wr_w0", 32'h1A10_2010, 1, wr_data[4], '0, 0, 0, 0, 0);
    add_row("udma_rd_w0", 32'h1A10_2010, 0, '0, wr_data[4], 0, 0, 0, 0);
    add_row("udma_wr_w3", 32'h1A10_3FF0, 1, wr_data[5], '0, 0, 3, 0, 0);
    add_row("udma_rd_w3", 32'h1A10_3FF0, 0, '0, wr_data[5], 0, 3, 0, 0);
    add_row("miss_wr", 32'h1A10_9000, 1, wr_data[6], '0, 1, 0, 0, 1);
    add_row("miss_rd", 32'h1A10_9000, 0, '0, '0, 1, 0, 0, 1);
    add_row("gpio_bad_idx", 32'h1A10_1008, 0, '0, '0, 1, 0, 0, 0);
    add_row("soc_bad_idx_wr", 32'h1A10_4010, 1, wr_data[6], '0, 1, 0, 0, 0);
    add_row("timer_bad_offs", 32'h1A10_B00C, 0, '0, '0, 1, 0, 0, 0);
    add_row("udma_stall", 32'h1A10_2020, 0, '0, '0, 1, STALL, 1, 0);
    add_row("udma_after_stall", 32'h1A10_2010, 0, '0, wr_data[4], 0, 1, 0, 0);
  endtask

  //******************************
  // main sequence
  //******************************

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    apb_req = '0;
    build_table();
    repeat (16) @(negedge clk);
    reset = 1'b0;

    check_value("reset_pready", 32'(1'b0), 32'(apb_resp.pready));
    check_value("reset_rto", 32'(1'b0), 32'(rto));
    check_value("reset_udma_psel", 32'(1'b0), 32'(udma_req.psel));
    check_value("reset_event", 32'(1'b0), 32'(timer_event));

    for (int i = 0; i < t_name.size(); i++) begin
      cur_wait        = t_wait[i];
      rto_udma_before = rto_udma_cnt;
      rto_any_before  = rto_any_cnt;
      psel_before     = psel_cnt;
      apb_transfer(t_addr[i], t_write[i], t_wdata[i], rd_data, rd_err, timed_out);
      if (timed_out) begin
        $display("%s: no pready from the bus within %0d cycles", t_name[i], XFER_LIMIT);
        timeouts++;
      end else begin
        check_value({t_name[i], " pslverr"}, 32'(t_err[i]), 32'(rd_err));
        // read data only counts on a read that ended without error
        if (!t_write[i] && !t_err[i]) begin
          check_value({t_name[i], " prdata"}, t_rdata[i], rd_data);
        end
        check_value({t_name[i], " rto_udma"}, 32'(t_rto[i]), 32'(rto_udma_cnt - rto_udma_before));
        check_value({t_name[i], " rto_any"}, 32'(t_rto[i]), 32'(rto_any_cnt - rto_any_before));
        if (t_nosel[i]) begin
          check_value({t_name[i], " psel_seen"}, 32'(0), 32'(psel_cnt - psel_before));
        end
      end
    end

    // register outputs after the table
    check_value("gpio_o[0]", wr_data[0], gpio[0]);
    check_value("gpio_o[1]", wr_data[1], gpio[1]);
    check_value("soc_ctrl_o[0]", wr_data[2], soc_ctrl[0]);
    check_value("soc_ctrl_o[1]", 32'(0), soc_ctrl[1]);
    check_value("soc_ctrl_o[2]", 32'(0), soc_ctrl[2]);
    check_value("soc_ctrl_o[3]", wr_data[3], soc_ctrl[3]);

    //******************************
    // timer event spacing
    //******************************

    cur_wait = 0;
    apb_transfer(TIMER_START_ADDR + 32'(TIMER_CMP_OFFS), 1, 32'(TIMER_CMP), rd_data, rd_err,
                 timed_out);
    if (timed_out) begin
      $display("timer_cmp_wr: no pready from the bus within %0d cycles", XFER_LIMIT);
      timeouts++;
    end else begin
      check_value("timer_cmp_wr pslverr", 32'(0), 32'(rd_err));
    end
    apb_transfer(TIMER_START_ADDR + 32'(TIMER_CTRL_OFFS), 1, 32'h1, rd_data, rd_err, timed_out);
    if (timed_out) begin
      $display("timer_ctrl_wr: no pready from the bus within %0d cycles", XFER_LIMIT);
      timeouts++;
    end else begin
      check_value("timer_ctrl_wr pslverr", 32'(0), 32'(rd_err));
    end

    wait_timer_event(interval, timed_out);
    if (timed_out) begin
      $display("timer_event: first event pulse never came");
      timeouts++;
    end else begin
      wait_timer_event(interval, timed_out);
      if (timed_out) begin
        $display("timer_event: second event pulse never came");
        timeouts++;
      end else begin
        check_value("timer_event_interval", 32'(TIMER_CMP + 1), 32'(interval));
      end
    end

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- periph_bus_top.f
periph_bus_pkg.sv
periph_apb_node.sv
periph_reg_bank.sv
periph_timer.sv
periph_bus_top.sv
tb_periph_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the peripheral bus testbench with Verilator, runs it into a log
# and decides pass or fail from the log contents.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_periph_bus \
  -f periph_bus_top.f \
  -o sim_periph_bus

./obj_dir/sim_periph_bus > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
